// File: Bender.yml
package:
  name: issue_core

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/isa_pkg.sv
      - verilog/pipe_pkg.sv
      - verilog/unit_issue_if.sv
      - verilog/decode_issue.sv
      - verilog/execute_stage.sv
      - verilog/regfile_writeback.sv
      - verilog/issue_core.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/clock_gen.sv
      - bench/issue_core_chk.sv
      - bench/issue_core_tb.sv

// File: bench/clock_gen.sv
// Testbench clock and reset
// 4 ns clock, reset held for 16 cycles and released on a falling edge

`timescale 1ns/1ps

module clock_gen #(
    parameter real PERIOD_NS    = 4.0,
    parameter int  RESET_CYCLES = 16
) (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2.0) clk = ~clk;
    end

    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

// File: bench/issue_core_chk.sv
// Bound checks on the issue core
// Exception pulse width, writes to x0 and ready right after reset

`timescale 1ns/1ps
`include "core_defines.svh"

module issue_core_chk (
    input logic                     clk,
    input logic                     rst,
    input logic                     instr_ready,
    input logic                     alu_wb_valid,
    input logic [`CORE_RADDR_W-1:0] alu_wb_rd,
    input logic                     mul_wb_valid,
    input logic [`CORE_RADDR_W-1:0] mul_wb_rd,
    input logic                     exc_valid
);
    int fail_count = 0;

    exc_single_cycle: assert property (
        @(posedge clk) disable iff (rst) exc_valid |=> !exc_valid
    ) else begin
        $error("exc_valid stayed high for two cycles");
        fail_count++;
    end

    alu_no_x0: assert property (
        @(posedge clk) disable iff (rst) alu_wb_valid |-> alu_wb_rd != '0
    ) else begin
        $error("ALU writeback targets x0");
        fail_count++;
    end

    mul_no_x0: assert property (
        @(posedge clk) disable iff (rst) mul_wb_valid |-> mul_wb_rd != '0
    ) else begin
        $error("multiply writeback targets x0");
        fail_count++;
    end

    // First cycle out of reset
    ready_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> instr_ready
    ) else begin
        $error("instr_ready low in the first cycle after reset");
        fail_count++;
    end

endmodule

// File: bench/issue_core_tb.sv
// Testbench for the issue core
// Replays the stimulus file into the DUT on falling edges and checks every
// writeback and exception pulse against the values listed per instruction

`timescale 1ns/1ps
`include "core_defines.svh"

module issue_core_tb;
    import pipe_pkg::*;

    localparam int MAX_LINES = 64;
    localparam int COLS      = 5;
    localparam int XLEN      = `CORE_XLEN;
    localparam int SETTLE_NS = 1;

    logic                     clk;
    logic                     rst;
    logic                     instr_valid;
    logic [XLEN-1:0]          instr;
    logic [XLEN-1:0]          pc;
    priv_e                    priv;
    logic                     flush;
    logic                     instr_ready;
    logic                     alu_wb_valid;
    logic [`CORE_RADDR_W-1:0] alu_wb_rd;
    logic [XLEN-1:0]          alu_wb_data;
    logic                     mul_wb_valid;
    logic [`CORE_RADDR_W-1:0] mul_wb_rd;
    logic [XLEN-1:0]          mul_wb_data;
    logic                     exc_valid;
    exc_code_e                exc_code;
    logic [XLEN-1:0]          exc_tval;
    logic [XLEN-1:0]          exc_pc;

    // Columns per line are kind, instruction, pc, privilege and expected value
    logic [31:0]                    stim [0:COLS*MAX_LINES-1];
    // Pending writebacks as {mul path, rd, value}
    logic [`CORE_RADDR_W+XLEN:0]    wb_expect [$];
    // Pending exceptions as {code, tval, pc}
    logic [3+2*XLEN:0]              exc_expect [$];
    int                             line_count;
    int                             errors;
    bit                             loaded;

    clock_gen clkgen (.clk(clk), .rst(rst));

    issue_core uut (.*);

    bind issue_core issue_core_chk chk (
        .clk(clk), .rst(rst), .instr_ready(instr_ready),
        .alu_wb_valid(alu_wb_valid), .alu_wb_rd(alu_wb_rd),
        .mul_wb_valid(mul_wb_valid), .mul_wb_rd(mul_wb_rd),
        .exc_valid(exc_valid)
    );

    //////////////////////////////////////////////////
    // Expected values

    // tval is the pc for EBREAK, the word for illegal patterns, else zero
    function automatic logic [XLEN-1:0] expected_tval(input logic [3:0] code,
                                                      input logic [XLEN-1:0] word,
                                                      input logic [XLEN-1:0] addr);
        case (code)
            EXC_BREAK:   return addr;
            EXC_ILLEGAL: return word;
            default:     return '0;
        endcase
    endfunction

    // MUL is the OP form with funct7 of one and funct3 of zero
    function automatic logic is_mul_word(input logic [XLEN-1:0] word);
        return (word[6:0] == 7'b0110011) && (word[14:12] == 3'b000) &&
               (word[31:25] == 7'b0000001);
    endfunction

    task automatic present_line(input int n);
        logic [31:0] kind;
        logic [31:0] expect_val;
        logic        took;
        kind = stim[COLS*n];
        expect_val = stim[COLS*n+4];
        @(negedge clk);
        instr_valid = 1'b1;
        instr = stim[COLS*n+1];
        pc = stim[COLS*n+2];
        priv = priv_e'(stim[COLS*n+3][1:0]);
        took = 1'b0;
        // Hold until an edge sees ready
        while (!took) begin
            #(SETTLE_NS);
            took = instr_ready;
            @(negedge clk);
        end
        instr_valid = 1'b0;
        case (kind)
            0: wb_expect.push_back({is_mul_word(instr), instr[11:7], expect_val});
            1: exc_expect.push_back({expect_val[3:0],
                                     expected_tval(expect_val[3:0], instr, pc), pc});
            default: begin
                // Accepted word now sits in the issue register
                flush = 1'b1;
                @(negedge clk);
                flush = 1'b0;
            end
        endcase
    endtask

    //////////////////////////////////////////////////
    // Writeback and exception checks

    task automatic check_wb(input string name, input logic on_mul,
                            input logic [`CORE_RADDR_W-1:0] rd,
                            input logic [XLEN-1:0] data);
        int idx;
        idx = -1;
        // Oldest pending entry for this rd
        for (int i = 0; i < wb_expect.size(); i++) begin
            if (idx < 0 && wb_expect[i][XLEN +: `CORE_RADDR_W] == rd) begin
                idx = i;
            end
        end
        assert (idx >= 0) else begin
            $display("Writeback to x%0d on %s arrived with none expected", rd, name);
            errors++;
        end
        if (idx >= 0) begin
            assert (on_mul == wb_expect[idx][XLEN+`CORE_RADDR_W]) else begin
                $display("Writeback to x%0d arrived on %s instead of the other path",
                         rd, name);
                errors++;
            end
            assert (data == wb_expect[idx][XLEN-1:0]) else begin
                $display("FAIL %s_data x%0d: got %h, expected %h",
                         name, rd, data, wb_expect[idx][XLEN-1:0]);
                errors++;
            end
            wb_expect.delete(idx);
        end
    endtask

    task automatic check_exc();
        logic [3+2*XLEN:0] e;
        assert (exc_expect.size() > 0) else begin
            $display("Exception pulse with code %h arrived with none expected", exc_code);
            errors++;
        end
        if (exc_expect.size() > 0) begin
            e = exc_expect.pop_front();
            assert (exc_code == e[2*XLEN +: 4]) else begin
                $display("FAIL exc_code: got %h, expected %h", exc_code, e[2*XLEN +: 4]);
                errors++;
            end
            assert (exc_tval == e[XLEN +: XLEN]) else begin
                $display("FAIL exc_tval: got %h, expected %h", exc_tval, e[XLEN +: XLEN]);
                errors++;
            end
            assert (exc_pc == e[XLEN-1:0]) else begin
                $display("FAIL exc_pc: got %h, expected %h", exc_pc, e[XLEN-1:0]);
                errors++;
            end
        end
    endtask

    task automatic report_counts();
        $display("Errors: %0d in testbench checks, %0d in bound assertions",
                 errors, uut.chk.fail_count);
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (alu_wb_valid) check_wb("alu_wb", 1'b0, alu_wb_rd, alu_wb_data);
            if (mul_wb_valid) check_wb("mul_wb", 1'b1, mul_wb_rd, mul_wb_data);
            if (exc_valid) check_exc();
        end
    end

    //////////////////////////////////////////////////
    // Main sequence
    initial begin
        instr_valid = 1'b0;
        instr = '0;
        pc = '0;
        priv = PRIV_M;
        flush = 1'b0;
        errors = 0;
        line_count = 0;
        void'($urandom(93));
        // Unused words stay outside the valid kind range
        for (int i = 0; i < COLS*MAX_LINES; i++) begin
            stim[i] = {16'hE5E5, i[15:0]};
        end
        $readmemh("bench/issue_stimulus.txt", stim);
        while (line_count < MAX_LINES && stim[COLS*line_count] < 3) begin
            line_count++;
        end
        loaded = 1'b1;
        assert (line_count > 0) else begin
            $display("Stimulus file holds no instruction lines");
            errors++;
        end
        @(negedge rst);
        for (int n = 0; n < line_count; n++) begin
            present_line(n);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end
        // Drain the queues and wait a few cycles for stray writebacks
        while (wb_expect.size() + exc_expect.size() != 0) begin
            @(negedge clk);
        end
        repeat (`CORE_MUL_STAGES + 4) @(negedge clk);
        report_counts();
        if (errors == 0 && uut.chk.fail_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog allows 40 cycles per line plus margin
    initial begin
        wait (loaded);
        repeat (40 * line_count + 100) @(posedge clk);
        $display("Timeout with %0d writebacks and %0d exceptions still outstanding",
                 wb_expect.size(), exc_expect.size());
        report_counts();
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

// File: bench/issue_stimulus.txt
// kind instr pc priv expect
// kind 0 writeback (expect = rd value), 1 exception (expect = code), 2 flushed
0 00500093 00000100 3 00000005
0 ffd00113 00000104 3 fffffffd
0 0f00c193 00000108 3 000000f5
0 70a0e213 0000010c 3 0000070f
0 0ff17293 00000110 3 000000fd
0 00112313 00000114 3 00000001
0 123453b7 00000118 3 12345000
0 00001417 0000011c 3 0000111c
0 008004ef 00000120 3 00000124
0 00208533 00000124 3 00000002
0 402085b3 00000128 3 00000008
0 00112633 0000012c 3 00000001
0 0041c6b3 00000130 3 000007fa
0 0062e733 00000134 3 000000fd
0 002277b3 00000138 3 0000070d
0 00750813 0000013c 3 00000009
0 00b808b3 00000140 3 00000011
0 02288933 00000144 3 ffffffcd
0 001909b3 00000148 3 ffffffd2
0 02108a33 0000014c 3 00000019
0 02320ab3 00000150 3 0006c15b
0 02210b33 00000154 3 00000009
0 10008b93 00000158 3 00000105
1 00000073 0000015c 0 00000008
1 00000073 00000160 1 00000009
1 00000073 00000164 3 0000000b
1 00100073 00000168 3 00000003
1 40007033 0000016c 3 00000002
0 02208d33 00000170 3 fffffff1
2 001d0cb3 00000174 3 00000000
0 010d0c93 00000178 3 00000001
0 017c8db3 0000017c 3 00000106

// File: list.f
+incdir+verilog
verilog/isa_pkg.sv
verilog/pipe_pkg.sv
verilog/unit_issue_if.sv
verilog/decode_issue.sv
verilog/execute_stage.sv
verilog/regfile_writeback.sv
verilog/issue_core.sv
bench/clock_gen.sv
bench/issue_core_chk.sv
bench/issue_core_tb.sv

// File: verilog/core_defines.svh
// Core sizing macros
// Data width, register count and multiplier depth shared by the issue pipeline

`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// Data and pc width
`define CORE_XLEN 32

// Architectural registers, x0 included
`define CORE_NREGS 32
`define CORE_RADDR_W $clog2(`CORE_NREGS)

// Multiply pipeline depth, 2 to 4 supported
`define CORE_MUL_STAGES 3

`endif

// File: verilog/decode_issue.sv
// Decode and issue stage
// Decodes one instruction, holds it in the issue register and sends it to
// the ALU or multiply path once its registers are free. ECALL, EBREAK and
// illegal words leave as a one-cycle exception pulse.

`timescale 1ns/1ps
`include "core_defines.svh"

module decode_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  isa_pkg::instr_t          instr,
    input  logic [`CORE_XLEN-1:0]    pc,
    input  pipe_pkg::priv_e          priv,
    input  logic                     flush,
    output logic                     instr_ready,
    output logic [`CORE_RADDR_W-1:0] rs1_addr,
    output logic [`CORE_RADDR_W-1:0] rs2_addr,
    input  logic [`CORE_XLEN-1:0]    rs1_data,
    input  logic [`CORE_XLEN-1:0]    rs2_data,
    input  logic [`CORE_NREGS-1:0]   busy_mask,
    output logic                     set_busy,
    output logic [`CORE_RADDR_W-1:0] set_rd,
    output logic                     exc_valid,
    output pipe_pkg::exc_code_e      exc_code,
    output logic [`CORE_XLEN-1:0]    exc_tval,
    output logic [`CORE_XLEN-1:0]    exc_pc,
    unit_issue_if.decode             ex
);
    import isa_pkg::*;
    import pipe_pkg::*;

    issue_pkt_t dec_pkt;
    exc_code_e  dec_exc_code;
    alu_op_e    f3_op;
    logic       f3_ok;
    issue_pkt_t iss;
    exc_code_e  iss_exc_code;
    logic       iss_valid;
    logic       iss_exc;
    logic       src_busy;
    logic       rd_busy;
    logic       issue_go;
    logic       exc_take;

    //////////////////////////////////////////////////
    // Decode
    always_comb begin
        f3_ok = 1'b1;
        case (instr.funct3)
            F3_ADD:  f3_op = ALU_ADD;
            F3_SLT:  f3_op = ALU_SLT;
            F3_XOR:  f3_op = ALU_XOR;
            F3_OR:   f3_op = ALU_OR;
            F3_AND:  f3_op = ALU_AND;
            default: begin
                f3_op = ALU_ADD;
                f3_ok = 1'b0;
            end
        endcase
    end

    always_comb begin
        dec_pkt = '0;
        dec_pkt.pc = pc;
        dec_pkt.instr = instr;
        dec_pkt.rd = instr.rd;
        dec_pkt.rs1 = instr.rs1;
        dec_pkt.rs2 = instr.rs2;
        dec_pkt.unit = UNIT_NONE;
        dec_pkt.alu_op = f3_op;
        dec_pkt.imm = {{(`CORE_XLEN-12){instr.funct7[6]}}, instr.funct7, instr.rs2};
        // Constant adder for LUI, AUIPC and the JAL link value
        dec_pkt.const_val = ((instr.opcode == OPC_LUI) ? '0 : pc) +
            ((instr.opcode inside {OPC_LUI, OPC_AUIPC}) ?
             {instr[31:12], 12'b0} : {{(`CORE_XLEN-3){1'b0}}, 3'd4});
        dec_exc_code = EXC_ILLEGAL;
        case (instr.opcode)
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                dec_pkt.unit = UNIT_ALU;
                dec_pkt.alu_op = ALU_PASS;
                dec_pkt.uses_rd = 1'b1;
            end
            OPC_OP_IMM: begin
                dec_pkt.unit = f3_ok ? UNIT_ALU : UNIT_NONE;
                dec_pkt.uses_rs1 = 1'b1;
                dec_pkt.uses_rd = 1'b1;
                dec_pkt.use_imm = 1'b1;
            end
            OPC_OP: begin
                dec_pkt.uses_rs1 = 1'b1;
                dec_pkt.uses_rs2 = 1'b1;
                dec_pkt.uses_rd = 1'b1;
                if (instr.funct7 == F7_MULDIV && instr.funct3 == F3_ADD) begin
                    dec_pkt.unit = UNIT_MUL;
                end else if (instr.funct7 == F7_ALT && instr.funct3 == F3_ADD) begin
                    dec_pkt.unit = UNIT_ALU;
                    dec_pkt.alu_op = ALU_SUB;
                end else if (instr.funct7 == F7_BASE && f3_ok) begin
                    dec_pkt.unit = UNIT_ALU;
                end
            end
            OPC_SYSTEM: begin
                if (instr == ECALL_WORD) begin
                    case (priv)
                        PRIV_S:  dec_exc_code = EXC_ECALL_S;
                        PRIV_M:  dec_exc_code = EXC_ECALL_M;
                        default: dec_exc_code = EXC_ECALL_U;
                    endcase
                end else if (instr == EBREAK_WORD) begin
                    dec_exc_code = EXC_BREAK;
                end
            end
            default: dec_exc_code = EXC_ILLEGAL;
        endcase
    end

    //////////////////////////////////////////////////
    // Issue register
    always_ff @(posedge clk) begin
        if (rst) begin
            iss_valid <= 1'b0;
        end else if (instr_ready) begin
            iss_valid <= instr_valid;
        end else if (flush) begin
            iss_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_ready) begin
            iss <= dec_pkt;
            iss_exc_code <= dec_exc_code;
        end
    end

    // Only excepting words decode to no unit
    assign iss_exc = (iss.unit == UNIT_NONE);

    assign src_busy = (iss.uses_rs1 & busy_mask[iss.rs1]) |
                      (iss.uses_rs2 & busy_mask[iss.rs2]);
    // Pending ALU result keeps rd busy up to its write edge,
    // so a MUL to the same rd waits as well
    assign rd_busy = iss.uses_rd & busy_mask[iss.rd];

    assign issue_go = iss_valid & ~iss_exc & ~flush & ~src_busy & ~rd_busy &
                      ((iss.unit != UNIT_MUL) | ex.mul_ready);
    assign exc_take = iss_valid & iss_exc & ~exc_valid & ~flush;
    assign instr_ready = ~iss_valid | issue_go | exc_take;

    assign rs1_addr = iss.rs1;
    assign rs2_addr = iss.rs2;
    assign set_busy = issue_go & iss.uses_rd & (iss.rd != '0);
    assign set_rd = iss.rd;

    assign ex.alu_start = issue_go & (iss.unit == UNIT_ALU);
    assign ex.mul_start = issue_go & (iss.unit == UNIT_MUL);
    assign ex.op = iss.alu_op;
    assign ex.a = rs1_data;
    assign ex.b = (iss.alu_op == ALU_PASS) ? iss.const_val :
                  iss.use_imm ? iss.imm : rs2_data;
    assign ex.rd = iss.rd;

    //////////////////////////////////////////////////
    // Exception pulse
    always_ff @(posedge clk) begin
        if (rst) begin
            exc_valid <= 1'b0;
        end else begin
            exc_valid <= exc_take;
        end
    end

    always_ff @(posedge clk) begin
        if (exc_take) begin
            exc_code <= iss_exc_code;
            exc_pc <= iss.pc;
            case (iss_exc_code)
                EXC_BREAK:   exc_tval <= iss.pc;
                EXC_ILLEGAL: exc_tval <= iss.instr;
                default:     exc_tval <= '0;
            endcase
        end
    end

endmodule

// File: verilog/execute_stage.sv
// Execute paths
// Single-cycle ALU with a registered result and a valid-tagged
// multiply pipeline that accepts a new operation every cycle

`timescale 1ns/1ps
`include "core_defines.svh"

module execute_stage (
    input  logic                     clk,
    input  logic                     rst,
    unit_issue_if.execute            ex,
    output logic                     alu_wb_valid,
    output logic [`CORE_RADDR_W-1:0] alu_wb_rd,
    output logic [`CORE_XLEN-1:0]    alu_wb_data,
    output logic                     mul_wb_valid,
    output logic [`CORE_RADDR_W-1:0] mul_wb_rd,
    output logic [`CORE_XLEN-1:0]    mul_wb_data
);
    import pipe_pkg::*;

    localparam int STAGES = `CORE_MUL_STAGES;

    logic [`CORE_XLEN-1:0]    alu_result;
    logic [`CORE_XLEN-1:0]    mul_a;
    logic [`CORE_XLEN-1:0]    mul_b;
    logic [`CORE_XLEN-1:0]    mul_lo;
    logic [STAGES-1:0]        mul_valid;
    logic [`CORE_RADDR_W-1:0] mul_rd [STAGES];
    logic [`CORE_XLEN-1:0]    mul_prod [1:STAGES-1];

    //////////////////////////////////////////////////
    // ALU
    always_comb begin
        alu_result = '0;
        case (ex.op)
            ALU_ADD:  alu_result = ex.a + ex.b;
            ALU_SUB:  alu_result = ex.a - ex.b;
            ALU_SLT:  alu_result[0] = $signed(ex.a) < $signed(ex.b);
            ALU_XOR:  alu_result = ex.a ^ ex.b;
            ALU_OR:   alu_result = ex.a | ex.b;
            ALU_AND:  alu_result = ex.a & ex.b;
            default:  alu_result = ex.b;
        endcase
    end

    // x0 results are computed but never written
    always_ff @(posedge clk) begin
        if (rst) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= ex.alu_start & (ex.rd != '0);
        end
    end

    always_ff @(posedge clk) begin
        alu_wb_rd <= ex.rd;
        alu_wb_data <= alu_result;
    end

    //////////////////////////////////////////////////
    // Multiplier
    // Stage 0 holds operands, stage 1 on holds the low product word
    assign mul_lo = mul_a * mul_b;
    assign ex.mul_ready = 1'b1;

    always_ff @(posedge clk) begin
        if (rst) begin
            mul_valid <= '0;
        end else begin
            mul_valid <= {mul_valid[STAGES-2:0], ex.mul_start & (ex.rd != '0)};
        end
    end

    always_ff @(posedge clk) begin
        mul_a <= ex.a;
        mul_b <= ex.b;
        mul_rd[0] <= ex.rd;
        mul_prod[1] <= mul_lo;
        for (int i = 1; i < STAGES; i++) begin
            mul_rd[i] <= mul_rd[i-1];
        end
        for (int i = 2; i < STAGES; i++) begin
            mul_prod[i] <= mul_prod[i-1];
        end
    end

    assign mul_wb_valid = mul_valid[STAGES-1];
    assign mul_wb_rd = mul_rd[STAGES-1];
    assign mul_wb_data = mul_prod[STAGES-1];

endmodule

// File: verilog/isa_pkg.sv
// RISC-V integer subset encodings
// Instruction fields, major opcodes and funct codes used by decode

package isa_pkg;

    // Major opcodes of the supported subset
    typedef enum logic [6:0] {
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU funct3 codes shared by OP and OP-IMM
    typedef enum logic [2:0] {
        F3_ADD = 3'b000,
        F3_SLT = 3'b010,
        F3_XOR = 3'b100,
        F3_OR  = 3'b110,
        F3_AND = 3'b111
    } funct3_e;

    localparam logic [6:0] F7_BASE   = 7'b0000000;
    localparam logic [6:0] F7_ALT    = 7'b0100000;
    localparam logic [6:0] F7_MULDIV = 7'b0000001;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_t;

    localparam logic [31:0] ECALL_WORD  = 32'h0000_0073;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

endpackage

// File: verilog/issue_core.sv
// In-order issue core
// Decode and issue, ALU and multiply paths, and the register file

`timescale 1ns/1ps
`include "core_defines.svh"

module issue_core (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     instr_valid,
    input  isa_pkg::instr_t          instr,
    input  logic [`CORE_XLEN-1:0]    pc,
    input  pipe_pkg::priv_e          priv,
    input  logic                     flush,
    output logic                     instr_ready,
    output logic                     alu_wb_valid,
    output logic [`CORE_RADDR_W-1:0] alu_wb_rd,
    output logic [`CORE_XLEN-1:0]    alu_wb_data,
    output logic                     mul_wb_valid,
    output logic [`CORE_RADDR_W-1:0] mul_wb_rd,
    output logic [`CORE_XLEN-1:0]    mul_wb_data,
    output logic                     exc_valid,
    output pipe_pkg::exc_code_e      exc_code,
    output logic [`CORE_XLEN-1:0]    exc_tval,
    output logic [`CORE_XLEN-1:0]    exc_pc
);
    logic [`CORE_RADDR_W-1:0] rs1_addr;
    logic [`CORE_RADDR_W-1:0] rs2_addr;
    logic [`CORE_XLEN-1:0]    rs1_data;
    logic [`CORE_XLEN-1:0]    rs2_data;
    logic [`CORE_NREGS-1:0]   busy_mask;
    logic                     set_busy;
    logic [`CORE_RADDR_W-1:0] set_rd;

    unit_issue_if ex_if ();

    decode_issue u_decode (
        .clk(clk), .rst(rst),
        .instr_valid(instr_valid), .instr(instr), .pc(pc), .priv(priv), .flush(flush),
        .instr_ready(instr_ready),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .busy_mask(busy_mask),
        .set_busy(set_busy), .set_rd(set_rd),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_tval(exc_tval), .exc_pc(exc_pc),
        .ex(ex_if)
    );

    execute_stage u_execute (
        .clk(clk), .rst(rst), .ex(ex_if),
        .alu_wb_valid(alu_wb_valid), .alu_wb_rd(alu_wb_rd), .alu_wb_data(alu_wb_data),
        .mul_wb_valid(mul_wb_valid), .mul_wb_rd(mul_wb_rd), .mul_wb_data(mul_wb_data)
    );

    regfile_writeback u_regfile (
        .clk(clk), .rst(rst),
        .rs1_addr(rs1_addr), .rs2_addr(rs2_addr),
        .rs1_data(rs1_data), .rs2_data(rs2_data), .busy_mask(busy_mask),
        .set_busy(set_busy), .set_rd(set_rd),
        .alu_wb_valid(alu_wb_valid), .alu_wb_rd(alu_wb_rd), .alu_wb_data(alu_wb_data),
        .mul_wb_valid(mul_wb_valid), .mul_wb_rd(mul_wb_rd), .mul_wb_data(mul_wb_data)
    );

endmodule

// File: verilog/pipe_pkg.sv
// Pipeline types
// Unit select, ALU operations, exception codes and the issue packet

`include "core_defines.svh"

package pipe_pkg;

    typedef enum logic [1:0] {UNIT_NONE, UNIT_ALU, UNIT_MUL} unit_e;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_XOR, ALU_OR, ALU_AND, ALU_PASS
    } alu_op_e;

    // Values follow mcause
    typedef enum logic [3:0] {
        EXC_ILLEGAL = 4'd2,
        EXC_BREAK   = 4'd3,
        EXC_ECALL_U = 4'd8,
        EXC_ECALL_S = 4'd9,
        EXC_ECALL_M = 4'd11
    } exc_code_e;

    typedef enum logic [1:0] {PRIV_U = 2'b00, PRIV_S = 2'b01, PRIV_M = 2'b11} priv_e;

    typedef struct packed {
        logic [`CORE_XLEN-1:0]    pc;
        isa_pkg::instr_t          instr;
        logic [`CORE_RADDR_W-1:0] rd;
        logic [`CORE_RADDR_W-1:0] rs1;
        logic [`CORE_RADDR_W-1:0] rs2;
        unit_e                    unit;
        alu_op_e                  alu_op;
        logic                     uses_rs1;
        logic                     uses_rs2;
        logic                     uses_rd;
        logic                     use_imm;
        logic [`CORE_XLEN-1:0]    imm;
        logic [`CORE_XLEN-1:0]    const_val;
    } issue_pkt_t;

endpackage

// File: verilog/regfile_writeback.sv
// Register file and scoreboard
// 31 writable registers with two write ports, one per execute path,
// and one busy bit per register set on issue and cleared on writeback

`timescale 1ns/1ps
`include "core_defines.svh"

module regfile_writeback (
    input  logic                     clk,
    input  logic                     rst,
    input  logic [`CORE_RADDR_W-1:0] rs1_addr,
    input  logic [`CORE_RADDR_W-1:0] rs2_addr,
    output logic [`CORE_XLEN-1:0]    rs1_data,
    output logic [`CORE_XLEN-1:0]    rs2_data,
    output logic [`CORE_NREGS-1:0]   busy_mask,
    input  logic                     set_busy,
    input  logic [`CORE_RADDR_W-1:0] set_rd,
    input  logic                     alu_wb_valid,
    input  logic [`CORE_RADDR_W-1:0] alu_wb_rd,
    input  logic [`CORE_XLEN-1:0]    alu_wb_data,
    input  logic                     mul_wb_valid,
    input  logic [`CORE_RADDR_W-1:0] mul_wb_rd,
    input  logic [`CORE_XLEN-1:0]    mul_wb_data
);
    logic [`CORE_XLEN-1:0]  regs [1:`CORE_NREGS-1];
    logic [`CORE_NREGS-1:0] set_mask;
    logic [`CORE_NREGS-1:0] clr_mask;

    // x0 reads as zero
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

    // Scoreboard keeps the two ports on different registers
    always_ff @(posedge clk) begin
        if (alu_wb_valid && alu_wb_rd != '0) begin
            regs[alu_wb_rd] <= alu_wb_data;
        end
        if (mul_wb_valid && mul_wb_rd != '0) begin
            regs[mul_wb_rd] <= mul_wb_data;
        end
    end

    always_comb begin
        set_mask = '0;
        clr_mask = '0;
        if (set_busy) set_mask[set_rd] = 1'b1;
        if (alu_wb_valid) clr_mask[alu_wb_rd] = 1'b1;
        if (mul_wb_valid) clr_mask[mul_wb_rd] = 1'b1;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_mask <= '0;
        end else begin
            busy_mask <= ((busy_mask & ~clr_mask) | set_mask) &
                         {{(`CORE_NREGS-1){1'b1}}, 1'b0};
        end
    end

endmodule

// File: verilog/unit_issue_if.sv
// Issue channel
// Carries one issued operation from decode to the ALU or multiply path

`timescale 1ns/1ps
`include "core_defines.svh"

interface unit_issue_if;
    import pipe_pkg::*;

    logic                     alu_start;
    logic                     mul_start;
    logic                     mul_ready;
    alu_op_e                  op;
    logic [`CORE_XLEN-1:0]    a;
    logic [`CORE_XLEN-1:0]    b;
    logic [`CORE_RADDR_W-1:0] rd;

    modport decode (output alu_start, mul_start, op, a, b, rd, input mul_ready);
    modport execute (input alu_start, mul_start, op, a, b, rd, output mul_ready);

endinterface
